// File: common/aes_rnd_pkg.sv
////////////////////////////////////////////////////////////
// Data-path definitions for the AES entropy path
// Entropy word, FIFO sizing, credit type and LFSR constants
// shared by the EDN fetch unit, the FIFO and the PRNG bank
////////////////////////////////////////////////////////////

`default_nettype none

package aes_rnd_pkg;

  ////////////////////////////////////////////////////////////
  // Entropy words
  ////////////////////////////////////////////////////////////

  // Width of one word delivered by the EDN
  localparam int unsigned ENTROPY_W = 32;

  typedef logic [ENTROPY_W-1:0] entropy_t;

  ////////////////////////////////////////////////////////////
  // Buffer and credits
  ////////////////////////////////////////////////////////////

  // Entries in the entropy FIFO, also the initial credit count
  localparam int unsigned FIFO_DEPTH = 4;
  localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);

  typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;

  // Holds 0 to FIFO_DEPTH inclusive
  typedef logic [2:0] credit_t;

  // One push from the fetch unit into the FIFO
  typedef struct packed {
    logic     valid;
    entropy_t data;
  } fifo_wr_t;

  ////////////////////////////////////////////////////////////
  // LFSR constants
  ////////////////////////////////////////////////////////////

  // Galois feedback masks, applied after a right shift
  localparam entropy_t CLR_LFSR_POLY = 32'h8020_0003;
  localparam entropy_t MSK_LFSR_POLY = 32'hA300_0000;

  // An all-zero state would lock up the LFSR
  localparam entropy_t ZERO_SEED_SUBST = 32'h9E37_79B9;

  localparam entropy_t CLR_RESET_SEED = 32'h1F3A_5C27;
  localparam entropy_t MSK_RESET_SEED = 32'h6B2D_90E5;

  // One Galois step shifts right and folds in the mask if a one dropped out
  function automatic entropy_t lfsr_step(entropy_t state, entropy_t poly);
    entropy_t nxt;
    nxt = state >> 1;
    if (state[0]) begin
      nxt = nxt ^ poly;
    end
    return nxt;
  endfunction

endpackage

`default_nettype wire

// File: common/aes_ctrl_pkg.sv
////////////////////////////////////////////////////////////
// Control definitions for the AES PRNG bank
// Opcodes, command and status structs, alerts, FSM states
////////////////////////////////////////////////////////////

`default_nettype none

package aes_ctrl_pkg;

  // Commands taken by the PRNG bank
  typedef enum logic [1:0] {
    OP_STEP       = 2'd0,
    OP_RESEED_CLR = 2'd1,
    OP_NOP        = 2'd2,
    OP_RSVD       = 2'd3
  } prng_op_e;

  typedef struct packed {
    logic     valid;
    prng_op_e op;
  } prng_cmd_t;

  // PRNG bank FSM
  typedef enum logic [1:0] {
    ST_IDLE     = 2'd0,
    ST_WAIT_CLR = 2'd1,
    ST_WAIT_MSK = 2'd2,
    ST_HALT     = 2'd3
  } prng_state_e;

  typedef struct packed {
    logic        idle;
    logic        done;
    logic [31:0] clr_prd;
    logic [31:0] msk_prd;
  } prng_status_t;

  typedef struct packed {
    logic recov;
    logic fatal;
  } alert_t;

  // Steps between automatic reseeds of the masking PRNG
  localparam int unsigned MSK_RESEED_INTERVAL = 8;
  localparam int unsigned STEP_CNT_W          = $clog2(MSK_RESEED_INTERVAL + 1);

  typedef logic [STEP_CNT_W-1:0] step_cnt_t;

endpackage

`default_nettype wire

// File: design/aes_edn_fetch.sv
////////////////////////////////////////////////////////////
// EDN fetch unit
// Prefetches entropy words while it holds credits and turns
// each acknowledged word into a push towards the FIFO
////////////////////////////////////////////////////////////

`default_nettype none

module aes_edn_fetch (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  output logic                   edn_req_o,
  input  logic                   edn_ack_i,
  input  aes_rnd_pkg::entropy_t  edn_data_i,
  input  logic                   escalate_i,
  input  logic                   credit_return_i,
  output aes_rnd_pkg::fifo_wr_t  fifo_wr_o
);
  import aes_rnd_pkg::*;

  credit_t  credit_q, credit_d;
  logic     req_q, req_d;
  logic     ack_acc;
  logic     wr_valid_q;
  entropy_t wr_data_q;

  ////////////////////////////////////////////////////////////
  // Request and credits
  ////////////////////////////////////////////////////////////

  // Only an ack against a live request counts
  assign ack_acc = req_q & edn_ack_i;

  // A raised request is held until acked, escalation or not.
  // A new one needs a free credit and no escalation
  assign req_d = req_q ? ~edn_ack_i : ((credit_q != '0) & ~escalate_i);

  assign credit_d = credit_q - credit_t'(ack_acc) + credit_t'(credit_return_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
    if (!rst_ni) begin
      req_q      <= 1'b0;
      credit_q   <= credit_t'(FIFO_DEPTH);
      wr_valid_q <= 1'b0;
    end else begin
      req_q      <= req_d;
      credit_q   <= credit_d;
      wr_valid_q <= ack_acc;
    end
  end

  // Word captured at ack, pushed in the next cycle
  always_ff @(posedge clk_i) begin : data_reg
    if (ack_acc) begin
      wr_data_q <= edn_data_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  assign edn_req_o       = req_q;
  assign fifo_wr_o.valid = wr_valid_q;
  assign fifo_wr_o.data  = wr_data_q;

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  // Returns from the FIFO must never overfill the counter
  a_credit_max: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    credit_q <= credit_t'(FIFO_DEPTH)
  ) else $error("EDN fetch credit count above FIFO depth");

  // EDN sees a stable request until it answers
  a_req_hold: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    edn_req_o && !edn_ack_i |=> edn_req_o
  ) else $error("EDN request dropped before ack");

endmodule

`default_nettype wire

// File: design/aes_entropy_fifo.sv
////////////////////////////////////////////////////////////
// Entropy FIFO between EDN fetch unit and PRNG bank
// Space is guaranteed by credits, so there is no ready;
// every pop sends one credit back to the fetch unit
////////////////////////////////////////////////////////////

`default_nettype none

module aes_entropy_fifo (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  aes_rnd_pkg::fifo_wr_t  fifo_wr_i,
  input  logic                   pop_i,
  output logic                   not_empty_o,
  output aes_rnd_pkg::entropy_t  head_o,
  output logic                   credit_return_o
);
  import aes_rnd_pkg::*;

  entropy_t  mem_q [FIFO_DEPTH];
  fifo_ptr_t wr_ptr_q, rd_ptr_q;
  credit_t   fill_q;
  logic      push, pop;

  // Pointer advance with wrap at the last entry
  function automatic fifo_ptr_t ptr_inc(fifo_ptr_t ptr);
    return (ptr == fifo_ptr_t'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push = fifo_wr_i.valid;
  assign pop  = pop_i & not_empty_o;

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin : mem_write
    if (push) begin
      mem_q[wr_ptr_q] <= fifo_wr_i.data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : ptr_regs
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      fill_q <= fill_q + credit_t'(push) - credit_t'(pop);
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  assign not_empty_o     = (fill_q != '0);
  assign head_o          = mem_q[rd_ptr_q];
  // Same cycle as the pop
  assign credit_return_o = pop;

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  // The fetch unit's credits must keep it from pushing into a full FIFO
  a_no_push_full: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    push |-> fill_q < credit_t'(FIFO_DEPTH)
  ) else $error("Entropy FIFO push while full");

  a_no_pop_empty: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> not_empty_o
  ) else $error("Entropy FIFO pop while empty");

endmodule

`default_nettype wire

// File: prng/aes_prng_bank.sv
////////////////////////////////////////////////////////////
// PRNG bank with clearing and masking LFSRs
// Runs step, reseed and nop commands, reseeds the masking
// PRNG on its own, and raises recoverable and fatal alerts
////////////////////////////////////////////////////////////

`default_nettype none

module aes_prng_bank (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  aes_ctrl_pkg::prng_cmd_t     cmd_i,
  output logic                        cmd_ready_o,
  input  logic                        escalate_i,
  input  logic                        not_empty_i,
  input  aes_rnd_pkg::entropy_t       head_i,
  output logic                        pop_o,
  output aes_ctrl_pkg::prng_status_t  status_o,
  output aes_ctrl_pkg::alert_t        alert_o
);
  import aes_rnd_pkg::*;
  import aes_ctrl_pkg::*;

  prng_state_e st_q, st_d;
  entropy_t    clr_q, msk_q;
  entropy_t    seed;
  step_cnt_t   step_cnt_q;
  logic        clr_pend_q, msk_pend_q;
  logic        done_q, recov_q, fatal_q;
  logic        cmd_acc, step_acc, nop_acc, rsvd_acc, reseed_acc;
  logic        clr_load, msk_load, cnt_wrap, halted;

  ////////////////////////////////////////////////////////////
  // Command decode
  ////////////////////////////////////////////////////////////

  assign cmd_ready_o = (st_q == ST_IDLE) & ~clr_pend_q & ~msk_pend_q & ~escalate_i;
  assign cmd_acc     = cmd_i.valid & cmd_ready_o;

  assign step_acc   = cmd_acc & (cmd_i.op == OP_STEP);
  assign reseed_acc = cmd_acc & (cmd_i.op == OP_RESEED_CLR);
  assign nop_acc    = cmd_acc & (cmd_i.op == OP_NOP);
  assign rsvd_acc   = cmd_acc & (cmd_i.op == OP_RSVD);

  ////////////////////////////////////////////////////////////
  // FSM and reseed arbitration
  ////////////////////////////////////////////////////////////

  // Clearing reseed wins over masking reseed
  always_comb begin
    st_d = st_q;
    unique case (st_q)
      ST_IDLE: begin
        if (clr_pend_q) begin
          st_d = ST_WAIT_CLR;
        end else if (msk_pend_q) begin
          st_d = ST_WAIT_MSK;
        end
      end
      ST_WAIT_CLR, ST_WAIT_MSK: begin
        if (not_empty_i) begin
          st_d = ST_IDLE;
        end
      end
      default: st_d = ST_HALT;
    endcase
    if (escalate_i) begin
      st_d = ST_HALT;
    end
  end

  assign pop_o    = ((st_q == ST_WAIT_CLR) | (st_q == ST_WAIT_MSK)) & not_empty_i & ~escalate_i;
  assign clr_load = pop_o & (st_q == ST_WAIT_CLR);
  assign msk_load = pop_o & (st_q == ST_WAIT_MSK);

  // A zero word would stall the LFSR
  assign seed = (head_i == '0) ? ZERO_SEED_SUBST : head_i;

  // Counter is checked one cycle after the step that fills it
  assign cnt_wrap = (step_cnt_q == step_cnt_t'(MSK_RESEED_INTERVAL));

  always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
    if (!rst_ni) begin
      st_q       <= ST_IDLE;
      step_cnt_q <= '0;
      clr_pend_q <= 1'b0;
      msk_pend_q <= 1'b0;
      done_q     <= 1'b0;
      recov_q    <= 1'b0;
      fatal_q    <= 1'b0;
    end else begin
      st_q <= st_d;
      if (cnt_wrap) begin
        step_cnt_q <= step_acc ? step_cnt_t'(1) : '0;
      end else if (step_acc) begin
        step_cnt_q <= step_cnt_q + 1'b1;
      end
      clr_pend_q <= (clr_pend_q & ~clr_load) | reseed_acc;
      msk_pend_q <= (msk_pend_q & ~msk_load) | cnt_wrap;
      done_q     <= step_acc | nop_acc | clr_load;
      recov_q    <= rsvd_acc;
      fatal_q    <= fatal_q | escalate_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // LFSRs
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : lfsr_regs
    if (!rst_ni) begin
      clr_q <= CLR_RESET_SEED;
      msk_q <= MSK_RESET_SEED;
    end else begin
      if (clr_load) begin
        clr_q <= seed;
      end else if (step_acc) begin
        clr_q <= lfsr_step(clr_q, CLR_LFSR_POLY);
      end
      if (msk_load) begin
        msk_q <= seed;
      end else if (step_acc) begin
        msk_q <= lfsr_step(msk_q, MSK_LFSR_POLY);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Status and alerts
  ////////////////////////////////////////////////////////////

  assign halted = (st_q == ST_HALT);

  assign status_o.idle    = (st_q == ST_IDLE) & ~clr_pend_q & ~msk_pend_q;
  assign status_o.done    = done_q;
  assign status_o.clr_prd = halted ? '0 : clr_q;
  assign status_o.msk_prd = halted ? '0 : msk_q;

  assign alert_o.recov = recov_q;
  assign alert_o.fatal = fatal_q;

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  // A pop needs a word and serves a pending reseed
  a_pop_not_empty: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pop_o |-> not_empty_i && (clr_pend_q || msk_pend_q)
  ) else $error("PRNG bank popped an empty FIFO or without a pending reseed");

  // Only reset leaves the halt state
  a_halt_sticky: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    halted |=> halted && alert_o.fatal
  ) else $error("PRNG bank left halt without reset");

endmodule

`default_nettype wire

// File: design/aes_rnd_top.sv
////////////////////////////////////////////////////////////
// Entropy path top level
// EDN fetch unit feeds the entropy FIFO, which feeds the
// PRNG bank; escalation reaches both fetch unit and bank
////////////////////////////////////////////////////////////

`default_nettype none

module aes_rnd_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  output logic                        edn_req_o,
  input  logic                        edn_ack_i,
  input  aes_rnd_pkg::entropy_t       edn_data_i,
  input  logic                        lc_escalate_i,
  input  aes_ctrl_pkg::prng_cmd_t     cmd_i,
  output logic                        cmd_ready_o,
  output aes_ctrl_pkg::prng_status_t  status_o,
  output aes_ctrl_pkg::alert_t        alert_o
);
  import aes_rnd_pkg::*;

  fifo_wr_t fifo_wr;
  logic     credit_return;
  logic     pop;
  logic     not_empty;
  entropy_t head;

  // Producer
  aes_edn_fetch u_fetch (
    .clk_i,
    .rst_ni,
    .edn_req_o,
    .edn_ack_i,
    .edn_data_i,
    .escalate_i      ( lc_escalate_i ),
    .credit_return_i ( credit_return ),
    .fifo_wr_o       ( fifo_wr       )
  );

  // Buffer
  aes_entropy_fifo u_fifo (
    .clk_i,
    .rst_ni,
    .fifo_wr_i       ( fifo_wr       ),
    .pop_i           ( pop           ),
    .not_empty_o     ( not_empty     ),
    .head_o          ( head          ),
    .credit_return_o ( credit_return )
  );

  // Consumer
  aes_prng_bank u_bank (
    .clk_i,
    .rst_ni,
    .cmd_i,
    .cmd_ready_o,
    .escalate_i  ( lc_escalate_i ),
    .not_empty_i ( not_empty     ),
    .head_i      ( head          ),
    .pop_o       ( pop           ),
    .status_o,
    .alert_o
  );

  // Ack to push takes one cycle, push to head one more
  a_fetch_latency: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    edn_req_o && edn_ack_i |-> ##2 not_empty
  ) else $error("Acked EDN word did not reach the FIFO head in time");

endmodule

`default_nettype wire

// File: test/aes_rnd_tests.svh
////////////////////////////////////////////////////////////
// Directed tests for the AES entropy path
// Included in the testbench module body; every test starts
// and ends just after a rising clock edge
////////////////////////////////////////////////////////////

`ifndef AES_RND_TESTS_SVH
`define AES_RND_TESTS_SVH

////////////////////////////////////////////////////////////
// Bookkeeping and checks
////////////////////////////////////////////////////////////

task automatic begin_test(input string name);
  cur_test  = name;
  test_errs = 0;
endtask

task automatic end_test();
  tests_run++;
  total_errs += test_errs;
  if (test_errs != 0) begin
    tests_failed++;
  end
  $display("Test %s finished with %0d errors", cur_test, test_errs);
endtask

task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
  assert (act === exp) else begin
    $display("[FAIL] %s: %s expected %h actual %h", cur_test, what, exp, act);
    test_errs++;
  end
endtask

task automatic report_problem(input string msg);
  $display("Error in %s: %s", cur_test, msg);
  test_errs++;
endtask

task automatic check_outputs();
  check_val("clr_prd", clr_m, status_o.clr_prd);
  check_val("msk_prd", msk_m, status_o.msk_prd);
endtask

// Next queued word as the bank loads it
task automatic take_seed(output entropy_t seed);
  seed = '0;
  assert (edn_words.size() != 0) else report_problem("no EDN word left for a reseed");
  if (edn_words.size() != 0) begin
    seed = edn_words.pop_front();
    if (seed == '0) begin
      seed = ZERO_SEED_SUBST;
    end
  end
endtask

////////////////////////////////////////////////////////////
// Command and wait helpers
////////////////////////////////////////////////////////////

// Hold the command from this edge until the bank takes it
task automatic issue_cmd(input prng_op_e op);
  int unsigned n;
  n = 0;
  cmd_i <= '{valid: 1'b1, op: op};
  @(negedge clk_i);
  while (!cmd_ready_o && n < WAIT_LIMIT) begin
    @(negedge clk_i);
    n++;
  end
  assert (cmd_ready_o) else report_problem("command was never accepted");
  @(posedge clk_i);
  cmd_i <= '{valid: 1'b0, op: OP_NOP};
endtask

task automatic wait_done();
  int unsigned n;
  n = 0;
  @(negedge clk_i);
  while (!status_o.done && n < WAIT_LIMIT) begin
    @(negedge clk_i);
    n++;
  end
  assert (status_o.done) else report_problem("timed out waiting for done");
endtask

task automatic wait_ready();
  int unsigned n;
  n = 0;
  @(negedge clk_i);
  while (!cmd_ready_o && n < WAIT_LIMIT) begin
    @(negedge clk_i);
    n++;
  end
  assert (cmd_ready_o) else report_problem("timed out waiting for cmd_ready");
endtask

task automatic wait_req(input logic level);
  int unsigned n;
  n = 0;
  @(negedge clk_i);
  while (edn_req_o !== level && n < WAIT_LIMIT) begin
    @(negedge clk_i);
    n++;
  end
  assert (edn_req_o === level) else
    report_problem(level ? "timed out waiting for an EDN request" : "EDN request never dropped");
endtask

task automatic wait_acks(input int unsigned count);
  int unsigned n;
  n = 0;
  @(negedge clk_i);
  while (edn_acks < count && n < WAIT_LIMIT) begin
    @(negedge clk_i);
    n++;
  end
  assert (edn_acks >= count) else report_problem("timed out waiting for EDN acks");
endtask

// FIFO holds FIFO_DEPTH words once every credit is spent
task automatic wait_fifo_full();
  int unsigned n;
  n = 0;
  @(negedge clk_i);
  while (edn_words.size() != FIFO_DEPTH && n < WAIT_LIMIT) begin
    @(negedge clk_i);
    n++;
  end
  assert (edn_words.size() == FIFO_DEPTH) else report_problem("FIFO never filled up");
endtask

task automatic step_and_check();
  issue_cmd(OP_STEP);
  step_model();
  @(negedge clk_i);
  check_val("done after step", 1, status_o.done);
  check_outputs();
  @(negedge clk_i);
  check_val("done one cycle later", 0, status_o.done);
  @(posedge clk_i);
endtask

////////////////////////////////////////////////////////////
// Tests
////////////////////////////////////////////////////////////

task automatic test_after_reset();
  begin_test("after_reset");
  @(negedge clk_i);
  check_val("cmd_ready", 1, cmd_ready_o);
  check_val("idle", 1, status_o.idle);
  check_val("done", 0, status_o.done);
  check_val("recov", 0, alert_o.recov);
  check_val("fatal", 0, alert_o.fatal);
  check_val("edn_req", 0, edn_req_o);
  check_outputs();
  wait_req(1'b1);
  wait_acks(FIFO_DEPTH);
  // Credits must stop prefetch at a full FIFO
  repeat (40) @(negedge clk_i);
  check_val("EDN acks without commands", FIFO_DEPTH, edn_acks);
  @(posedge clk_i);
  end_test();
endtask

task automatic test_clear_reseed();
  entropy_t seed;
  begin_test("clear_reseed");
  issue_cmd(OP_RESEED_CLR);
  wait_done();
  take_seed(seed);
  clr_m = seed;
  check_outputs();
  @(posedge clk_i);
  // Second word delivered is zero
  issue_cmd(OP_RESEED_CLR);
  wait_done();
  take_seed(seed);
  clr_m = seed;
  check_val("clr_prd after zero word", ZERO_SEED_SUBST, status_o.clr_prd);
  check_outputs();
  @(posedge clk_i);
  end_test();
endtask

task automatic test_steps();
  begin_test("steps");
  repeat (3) step_and_check();
  issue_cmd(OP_NOP);
  @(negedge clk_i);
  check_val("done after nop", 1, status_o.done);
  check_outputs();
  @(posedge clk_i);
  end_test();
endtask

task automatic test_masking_reseed();
  entropy_t    seed;
  int unsigned steps_left;
  begin_test("masking_reseed");
  steps_left = MSK_RESEED_INTERVAL - steps_m;
  repeat (steps_left - 1) step_and_check();
  issue_cmd(OP_STEP);
  step_model();
  // Clearing reseed shows up in the done cycle of the last step
  issue_cmd(OP_RESEED_CLR);
  @(negedge clk_i);
  check_val("cmd_ready with reseeds pending", 0, cmd_ready_o);
  wait_done();
  take_seed(seed);
  clr_m = seed;
  check_outputs();
  wait_ready();
  take_seed(seed);
  msk_m = seed;
  check_outputs();
  check_val("done after masking reseed", 0, status_o.done);
  @(posedge clk_i);
  end_test();
endtask

task automatic test_invalid_opcode();
  begin_test("invalid_opcode");
  issue_cmd(OP_RSVD);
  @(negedge clk_i);
  check_val("recov", 1, alert_o.recov);
  check_val("done", 0, status_o.done);
  @(negedge clk_i);
  check_val("recov one cycle later", 0, alert_o.recov);
  check_val("done one cycle later", 0, status_o.done);
  check_val("cmd_ready", 1, cmd_ready_o);
  check_outputs();
  @(posedge clk_i);
  end_test();
endtask

task automatic test_escalation();
  entropy_t    seed;
  int unsigned acks;
  begin_test("escalation");
  wait_fifo_full();
  // Next request is left waiting so escalation finds it outstanding
  edn_stall = 1'b1;
  @(posedge clk_i);
  issue_cmd(OP_RESEED_CLR);
  wait_done();
  take_seed(seed);
  clr_m = seed;
  check_outputs();
  wait_req(1'b1);
  @(posedge clk_i);
  lc_escalate_i <= 1'b1;
  @(negedge clk_i);
  check_val("fatal in escalation cycle", 0, alert_o.fatal);
  check_val("cmd_ready", 0, cmd_ready_o);
  repeat (4) begin
    @(negedge clk_i);
    check_val("fatal", 1, alert_o.fatal);
    check_val("idle", 0, status_o.idle);
    check_val("cmd_ready", 0, cmd_ready_o);
    check_val("clr_prd", 0, status_o.clr_prd);
    check_val("msk_prd", 0, status_o.msk_prd);
    check_val("held edn_req", 1, edn_req_o);
  end
  acks = edn_acks;
  edn_stall = 1'b0;
  wait_acks(acks + 1);
  wait_req(1'b0);
  acks = edn_acks;
  repeat (20) begin
    @(negedge clk_i);
    check_val("edn_req after escalation", 0, edn_req_o);
    check_val("sticky fatal", 1, alert_o.fatal);
  end
  check_val("EDN acks after escalation", acks, edn_acks);
  @(posedge clk_i);
  end_test();
endtask

`endif

// File: test/aes_rnd_tb.sv
////////////////////////////////////////////////////////////
// Testbench top for the AES entropy path
// Clock, reset, EDN responder and PRNG reference model;
// runs the directed tests and prints the final report
////////////////////////////////////////////////////////////

`default_nettype none

module aes_rnd_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import aes_rnd_pkg::*;
  import aes_ctrl_pkg::*;

  localparam int unsigned WAIT_LIMIT = 200;
  // Delivery index of the all-zero EDN word
  localparam int unsigned ZERO_WORD_IDX = 1;

  logic         clk_i;
  logic         rst_ni;
  logic         edn_req_o;
  logic         edn_ack_i;
  entropy_t     edn_data_i;
  logic         lc_escalate_i;
  prng_cmd_t    cmd_i;
  logic         cmd_ready_o;
  prng_status_t status_o;
  alert_t       alert_o;

  // EDN responder state with words kept in delivery order
  entropy_t    edn_words[$];
  int unsigned edn_acks;
  bit          edn_stall;

  // Reference model of both PRNGs
  entropy_t    clr_m;
  entropy_t    msk_m;
  int unsigned steps_m;

  string       cur_test;
  int unsigned test_errs;
  int unsigned total_errs;
  int unsigned tests_run;
  int unsigned tests_failed;

  aes_rnd_top UUT (
    .clk_i,
    .rst_ni,
    .edn_req_o,
    .edn_ack_i,
    .edn_data_i,
    .lc_escalate_i,
    .cmd_i,
    .cmd_ready_o,
    .status_o,
    .alert_o
  );

  // Galois step shifts right and XORs the mask if the dropped bit was one
  function automatic entropy_t lfsr_advance(entropy_t cur, entropy_t mask);
    return cur[0] ? ((cur >> 1) ^ mask) : (cur >> 1);
  endfunction

  function automatic void step_model();
    clr_m = lfsr_advance(clr_m, CLR_LFSR_POLY);
    msk_m = lfsr_advance(msk_m, MSK_LFSR_POLY);
    steps_m++;
    if (steps_m == MSK_RESEED_INTERVAL) begin
      steps_m = 0;
    end
  endfunction

  `include "aes_rnd_tests.svh"

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #4 clk_i = ~clk_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // EDN responder
  ////////////////////////////////////////////////////////////

  // Acks each request after 0 to 3 cycles, unless stalled
  initial begin : edn_responder
    int unsigned delay;
    bit          busy;
    entropy_t    word;
    delay = 0;
    busy  = 1'b0;
    void'($urandom(7));
    forever begin
      @(posedge clk_i);
      if (edn_ack_i) begin
        // Handshake completes at this edge
        edn_ack_i <= 1'b0;
        busy = 1'b0;
      end else begin
        if (!busy && edn_req_o && !edn_stall) begin
          busy  = 1'b1;
          delay = $urandom_range(3, 0);
        end else if (busy && delay != 0) begin
          delay--;
        end
        if (busy && delay == 0) begin
          word = (edn_acks == ZERO_WORD_IDX) ? '0 : entropy_t'($urandom());
          edn_ack_i  <= 1'b1;
          edn_data_i <= word;
          edn_words.push_back(word);
          edn_acks++;
        end
      end
    end
  end

  initial begin : main
    rst_ni        = 1'b0;
    edn_ack_i     = 1'b0;
    edn_data_i    = '0;
    lc_escalate_i = 1'b0;
    cmd_i         = '{valid: 1'b0, op: OP_NOP};
    edn_stall     = 1'b0;
    edn_acks      = 0;
    clr_m         = CLR_RESET_SEED;
    msk_m         = MSK_RESET_SEED;
    steps_m       = 0;
    cur_test      = "reset";
    test_errs     = 0;
    total_errs    = 0;
    tests_run     = 0;
    tests_failed  = 0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    test_after_reset();
    test_clear_reseed();
    test_steps();
    test_masking_reseed();
    test_invalid_opcode();
    test_escalation();

    $display("Summary: %0d tests run, %0d failed, %0d errors",
             tests_run, tests_failed, total_errs);
    if (total_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+test
common/aes_rnd_pkg.sv
common/aes_ctrl_pkg.sv
design/aes_edn_fetch.sv
design/aes_entropy_fifo.sv
prng/aes_prng_bank.sv
design/aes_rnd_top.sv
test/aes_rnd_tb.sv
